// ==== logic/display_pkg.sv ====
// --------------------
// Display frame store package
// Frame geometry, packing widths and the host write credit count
// --------------------
package display_pkg;

    // Visible frame size
    localparam int FRAME_WIDTH = 640;
    localparam int FRAME_HEIGHT = 400;
    localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;

    // Pixel addressing, one 4-bit pixel per address
    localparam int PIXEL_ADDRESS_WIDTH = 18;
    localparam int PIXEL_WIDTH = 4;

    // Eight pixels share one memory word
    localparam int PIXELS_PER_WORD = 8;
    localparam int LANE_WIDTH = 3;
    localparam int WORD_WIDTH = PIXELS_PER_WORD * PIXEL_WIDTH;

    // Word addressing inside one buffer
    localparam int WORD_ADDRESS_WIDTH = PIXEL_ADDRESS_WIDTH - LANE_WIDTH;
    localparam int FRAME_WORDS = FRAME_PIXELS / PIXELS_PER_WORD;

    // Host owns this many writes in flight
    localparam int WRITE_CREDITS = 4;

endpackage

// ==== logic/pixel_command_decode.sv ====
// --------------------
// Pixel command decode
// Credit-counted write queue, splits pixel addresses into word and lane
// --------------------
`timescale 1ns/1ps

module pixel_command_decode (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic pixel_write_valid,
    input  logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address,
    input  logic [display_pkg::PIXEL_WIDTH-1:0] pixel_write_data,
    output logic pixel_write_credit,
    output logic word_update_valid,
    output logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] word_update_address,
    output logic [display_pkg::LANE_WIDTH-1:0] word_update_lane,
    output logic [display_pkg::PIXEL_WIDTH-1:0] word_update_pixel,
    input  logic word_update_ready,
    output logic queue_empty
);

    // Queue storage
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] entry_word [display_pkg::WRITE_CREDITS];
    logic [display_pkg::LANE_WIDTH-1:0] entry_lane [display_pkg::WRITE_CREDITS];
    logic [display_pkg::PIXEL_WIDTH-1:0] entry_pixel [display_pkg::WRITE_CREDITS];

    logic [$clog2(display_pkg::WRITE_CREDITS)-1:0] write_pointer;
    logic [$clog2(display_pkg::WRITE_CREDITS)-1:0] read_pointer;
    logic [$clog2(display_pkg::WRITE_CREDITS+1)-1:0] entry_count;

    // Credits owed for writes dropped at entry
    logic [$clog2(display_pkg::WRITE_CREDITS+1)-1:0] drop_owed;

    logic in_frame;
    logic push;
    logic pop;

    // Only addresses inside the frame are queued
    assign in_frame = pixel_write_address < display_pkg::FRAME_PIXELS;
    assign push = pixel_write_valid && in_frame;
    assign pop = word_update_valid && word_update_ready;

    // Head of queue goes straight to the execute stage
    assign word_update_valid = entry_count != '0;
    assign word_update_address = entry_word[read_pointer];
    assign word_update_lane = entry_lane[read_pointer];
    assign word_update_pixel = entry_pixel[read_pointer];
    assign queue_empty = entry_count == '0;

    // One credit per handoff; a dropped write waits if a handoff takes the cycle
    assign pixel_write_credit = pop || (drop_owed != '0);

    always_ff @(posedge clock_in) begin
        // Split address on entry
        if (push) begin
            entry_word[write_pointer] <= pixel_write_address[display_pkg::PIXEL_ADDRESS_WIDTH-1:
                                                             display_pkg::LANE_WIDTH];
            entry_lane[write_pointer] <= pixel_write_address[display_pkg::LANE_WIDTH-1:0];
            entry_pixel[write_pointer] <= pixel_write_data;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            write_pointer <= '0;
            read_pointer <= '0;
            entry_count <= '0;
            drop_owed <= '0;
        end else begin
            if (push) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (pop) begin
                read_pointer <= read_pointer + 1'b1;
            end
            // Occupancy tracks push and pop together
            case ({push, pop})
                2'b10: entry_count <= entry_count + 1'b1;
                2'b01: entry_count <= entry_count - 1'b1;
                default: entry_count <= entry_count;
            endcase
            // Out of frame write owes its credit back
            if (pixel_write_valid && !in_frame && (pop || drop_owed == '0)) begin
                drop_owed <= drop_owed + 1'b1;
            end else if (!(pixel_write_valid && !in_frame) && !pop && drop_owed != '0) begin
                drop_owed <= drop_owed - 1'b1;
            end
        end
    end

endmodule

// ==== logic/pixel_word_update.sv ====
// --------------------
// Pixel word update
// Read-modify-write of one pixel lane in the back buffer
// --------------------
`timescale 1ns/1ps

module pixel_word_update (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic word_update_valid,
    input  logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] word_update_address,
    input  logic [display_pkg::LANE_WIDTH-1:0] word_update_lane,
    input  logic [display_pkg::PIXEL_WIDTH-1:0] word_update_pixel,
    output logic word_update_ready,
    output logic update_busy,
    output logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_read_address,
    output logic back_write_enable,
    output logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_write_address,
    output logic [display_pkg::WORD_WIDTH-1:0] back_write_data,
    input  logic [display_pkg::WORD_WIDTH-1:0] back_read_data
);

    // Idle takes a command and issues its read, merge writes it back
    typedef enum logic {
        UPDATE_IDLE,
        UPDATE_MERGE
    } update_state_t;

    update_state_t update_state;

    logic accept;

    // Command held across the read latency
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] held_address;
    logic [display_pkg::LANE_WIDTH-1:0] held_lane;
    logic [display_pkg::PIXEL_WIDTH-1:0] held_pixel;

    logic [display_pkg::WORD_WIDTH-1:0] merged_word;

    assign word_update_ready = update_state == UPDATE_IDLE;
    assign accept = word_update_valid && word_update_ready;

    // Busy from the read cycle through the write cycle
    assign update_busy = accept || (update_state == UPDATE_MERGE);

    // Read issued in the handoff cycle, data back next cycle
    assign back_read_address = word_update_address;

    // Replace only the addressed nibble
    always_comb begin
        merged_word = back_read_data;
        merged_word[held_lane*display_pkg::PIXEL_WIDTH +: display_pkg::PIXEL_WIDTH] = held_pixel;
    end

    assign back_write_enable = update_state == UPDATE_MERGE;
    assign back_write_address = held_address;
    assign back_write_data = merged_word;

    always_ff @(posedge clock_in) begin
        if (accept) begin
            held_address <= word_update_address;
            held_lane <= word_update_lane;
            held_pixel <= word_update_pixel;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            update_state <= UPDATE_IDLE;
        end else begin
            case (update_state)
                UPDATE_IDLE: begin
                    if (accept) begin
                        update_state <= UPDATE_MERGE;
                    end
                end
                // Write lands this cycle, ready again after it
                default: begin
                    update_state <= UPDATE_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/frame_buffer_pair.sv ====
// --------------------
// Frame buffer pair
// Two word memories, display and update ports swapped by front_is_b
// --------------------
`timescale 1ns/1ps

module frame_buffer_pair (
    input  logic clock_in,
    input  logic front_is_b,
    input  logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] front_read_address,
    input  logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_read_address,
    input  logic back_write_enable,
    input  logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_write_address,
    input  logic [display_pkg::WORD_WIDTH-1:0] back_write_data,
    output logic [display_pkg::WORD_WIDTH-1:0] front_read_data,
    output logic [display_pkg::WORD_WIDTH-1:0] back_read_data
);

    // Registered read word of each buffer, index 0 is A
    logic [display_pkg::WORD_WIDTH-1:0] read_word [2];

    // Routing at the time the reads were issued
    logic read_front_is_b;

    genvar buffer_index;
    generate
        for (buffer_index = 0; buffer_index < 2; buffer_index++) begin : g_buffer
            logic [display_pkg::WORD_WIDTH-1:0] words [display_pkg::FRAME_WORDS] =
                '{default: '0};
            logic is_front;
            logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] read_address;

            assign is_front = front_is_b == 1'(buffer_index);

            // Front buffer serves the display, back buffer the updater
            assign read_address = is_front ? front_read_address : back_read_address;

            always_ff @(posedge clock_in) begin
                read_word[buffer_index] <= words[read_address];
                // Writes never reach the displayed buffer
                if (!is_front && back_write_enable) begin
                    words[back_write_address] <= back_write_data;
                end
            end
        end
    endgenerate

    always_ff @(posedge clock_in) begin
        read_front_is_b <= front_is_b;
    end

    // Steer returned words by the routing they were read with
    assign front_read_data = read_front_is_b ? read_word[1] : read_word[0];
    assign back_read_data = read_front_is_b ? read_word[0] : read_word[1];

endmodule

// ==== logic/buffer_swap_control.sv ====
// --------------------
// Buffer swap control
// Syncs the switch request and swaps buffers at frame start when drained
// --------------------
`timescale 1ns/1ps

module buffer_swap_control (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic switch_write_buffer,
    input  logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_read_address,
    input  logic queue_empty,
    input  logic update_busy,
    output logic front_is_b,
    output logic buffer_swapped
);

    // Two stage capture of the switch level
    logic [1:0] switch_sync;
    logic switch_rise;
    logic swap_pending;
    logic swap_now;

    // Newer sample high, older low
    assign switch_rise = switch_sync == 2'b01;

    // Frame restart with nothing queued or mid-update
    assign swap_now = swap_pending && (pixel_read_address == '0) && queue_empty && !update_busy;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            switch_sync <= '0;
            swap_pending <= 1'b0;
            front_is_b <= 1'b0;
            buffer_swapped <= 1'b0;
        end else begin
            switch_sync <= {switch_sync[0], switch_write_buffer};
            buffer_swapped <= swap_now;
            if (swap_now) begin
                front_is_b <= !front_is_b;
                swap_pending <= 1'b0;
            end
            // A fresh request wins over a clear in the same cycle
            if (switch_rise) begin
                swap_pending <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/display_readout.sv ====
// --------------------
// Display readout
// Picks the addressed pixel from the front word, zero outside the frame
// --------------------
`timescale 1ns/1ps

module display_readout (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_read_address,
    output logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] front_read_address,
    input  logic [display_pkg::WORD_WIDTH-1:0] front_read_data,
    output logic [display_pkg::PIXEL_WIDTH-1:0] pixel_read_data
);

    logic in_frame;

    // Lane and range flag follow the memory read by one cycle
    logic [display_pkg::LANE_WIDTH-1:0] lane_q;
    logic in_frame_q;

    assign in_frame = pixel_read_address < display_pkg::FRAME_PIXELS;

    // Out of frame addresses park on word zero
    assign front_read_address = in_frame
        ? pixel_read_address[display_pkg::PIXEL_ADDRESS_WIDTH-1:display_pkg::LANE_WIDTH]
        : '0;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            lane_q <= '0;
            in_frame_q <= 1'b0;
        end else begin
            lane_q <= pixel_read_address[display_pkg::LANE_WIDTH-1:0];
            in_frame_q <= in_frame;
        end
    end

    // Nibble select, blanked past the frame
    assign pixel_read_data = in_frame_q
        ? front_read_data[lane_q*display_pkg::PIXEL_WIDTH +: display_pkg::PIXEL_WIDTH]
        : '0;

endmodule

// ==== logic/display_buffers.sv ====
// --------------------
// Display buffers top level
// Double-buffered 4-bit frame store with credit-based host writes
// --------------------
`timescale 1ns/1ps

module display_buffers (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic pixel_write_valid,
    input  logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address,
    input  logic [display_pkg::PIXEL_WIDTH-1:0] pixel_write_data,
    input  logic switch_write_buffer,
    input  logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_read_address,
    output logic pixel_write_credit,
    output logic [display_pkg::PIXEL_WIDTH-1:0] pixel_read_data,
    output logic buffer_swapped
);

    // Decode to execute
    logic word_update_valid;
    logic word_update_ready;
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] word_update_address;
    logic [display_pkg::LANE_WIDTH-1:0] word_update_lane;
    logic [display_pkg::PIXEL_WIDTH-1:0] word_update_pixel;

    // Write path state seen by swap control
    logic queue_empty;
    logic update_busy;

    // Back buffer port
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_read_address;
    logic [display_pkg::WORD_WIDTH-1:0] back_read_data;
    logic back_write_enable;
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] back_write_address;
    logic [display_pkg::WORD_WIDTH-1:0] back_write_data;

    // Front buffer port and routing
    logic [display_pkg::WORD_ADDRESS_WIDTH-1:0] front_read_address;
    logic [display_pkg::WORD_WIDTH-1:0] front_read_data;
    logic front_is_b;

    pixel_command_decode u_decode (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .pixel_write_valid  (pixel_write_valid),
        .pixel_write_address(pixel_write_address),
        .pixel_write_data   (pixel_write_data),
        .pixel_write_credit (pixel_write_credit),
        .word_update_valid  (word_update_valid),
        .word_update_address(word_update_address),
        .word_update_lane   (word_update_lane),
        .word_update_pixel  (word_update_pixel),
        .word_update_ready  (word_update_ready),
        .queue_empty        (queue_empty)
    );

    pixel_word_update u_update (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .word_update_valid  (word_update_valid),
        .word_update_address(word_update_address),
        .word_update_lane   (word_update_lane),
        .word_update_pixel  (word_update_pixel),
        .word_update_ready  (word_update_ready),
        .update_busy        (update_busy),
        .back_read_address  (back_read_address),
        .back_write_enable  (back_write_enable),
        .back_write_address (back_write_address),
        .back_write_data    (back_write_data),
        .back_read_data     (back_read_data)
    );

    frame_buffer_pair u_buffers (
        .clock_in          (clock_in),
        .front_is_b        (front_is_b),
        .front_read_address(front_read_address),
        .back_read_address (back_read_address),
        .back_write_enable (back_write_enable),
        .back_write_address(back_write_address),
        .back_write_data   (back_write_data),
        .front_read_data   (front_read_data),
        .back_read_data    (back_read_data)
    );

    buffer_swap_control u_swap (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .switch_write_buffer(switch_write_buffer),
        .pixel_read_address (pixel_read_address),
        .queue_empty        (queue_empty),
        .update_busy        (update_busy),
        .front_is_b         (front_is_b),
        .buffer_swapped     (buffer_swapped)
    );

    display_readout u_readout (
        .clock_in          (clock_in),
        .reset_n_in        (reset_n_in),
        .pixel_read_address(pixel_read_address),
        .front_read_address(front_read_address),
        .front_read_data   (front_read_data),
        .pixel_read_data   (pixel_read_data)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// --------------------
// Testbench clock and reset
// --------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock_in,
    output logic reset_n_in
);

    // 10 ns period
    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = !clock_in;
    end

    // Reset held low over the first two rising edges
    initial begin
        reset_n_in = 1'b0;
        repeat (2) @(posedge clock_in);
        #1 reset_n_in = 1'b1;
    end

endmodule

// ==== bench/display_buffers_assertions.sv ====
// --------------------
// Display buffers assertions
// Credit and swap rules checked at the top level
// --------------------
`timescale 1ns/1ps

module display_buffers_assertions (
    input logic clock_in,
    input logic reset_n_in,
    input logic pixel_write_valid,
    input logic pixel_write_credit,
    input logic buffer_swapped,
    input logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_read_address,
    input logic queue_empty,
    input logic update_busy
);

    // Host side credit balance
    int credits_held;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            credits_held <= display_pkg::WRITE_CREDITS;
        end else begin
            credits_held <= credits_held - int'(pixel_write_valid) + int'(pixel_write_credit);
        end
    end

    // No write without a credit
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        pixel_write_valid |-> credits_held != 0)
        else $error("write valid while no credit is held");

    // Balance never exceeds the initial grant
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        credits_held <= display_pkg::WRITE_CREDITS)
        else $error("more credits returned than spent");

    // Swap took effect at frame start with the write path drained
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        buffer_swapped |-> $past(pixel_read_address) == '0)
        else $error("swap outside the address zero period");

    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        buffer_swapped |-> $past(queue_empty) && !$past(update_busy))
        else $error("swap while a write was pending");

    // Swap pulse is one cycle wide
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        buffer_swapped |=> !buffer_swapped)
        else $error("swap pulse longer than one cycle");

endmodule

bind display_buffers display_buffers_assertions u_assertions (
    .clock_in          (clock_in),
    .reset_n_in        (reset_n_in),
    .pixel_write_valid (pixel_write_valid),
    .pixel_write_credit(pixel_write_credit),
    .buffer_swapped    (buffer_swapped),
    .pixel_read_address(pixel_read_address),
    .queue_empty       (queue_empty),
    .update_busy       (update_busy)
);

// ==== bench/display_buffers_tb.sv ====
// --------------------
// Display buffers testbench
// Frame scans with host writes, checked against a double frame model
// --------------------
`timescale 1ns/1ps

module display_buffers_tb;

    localparam int SCAN_CYCLES = display_pkg::FRAME_PIXELS + 20;
    localparam int SCANS = 6;
    localparam int WRITE_LIMIT = 400;
    localparam int TIMEOUT_CYCLES = SCANS * SCAN_CYCLES + WRITE_LIMIT * 4 + 1000;
    localparam int WRITE_START = 1000;
    localparam int WRITE_STOP = display_pkg::FRAME_PIXELS - 100;

    logic clock_in;
    logic reset_n_in;
    logic pixel_write_valid;
    logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address;
    logic [display_pkg::PIXEL_WIDTH-1:0] pixel_write_data;
    logic switch_write_buffer;
    logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] pixel_read_address;
    logic pixel_write_credit;
    logic [display_pkg::PIXEL_WIDTH-1:0] pixel_read_data;
    logic buffer_swapped;

    // Two model frames and the index of the displayed one
    logic [display_pkg::PIXEL_WIDTH-1:0] frame_model [2][display_pkg::FRAME_PIXELS];
    bit front_sel;

    // Pending host writes with the address above the pixel data
    logic [display_pkg::PIXEL_ADDRESS_WIDTH+display_pkg::PIXEL_WIDTH-1:0] write_queue [$];

    int credits_held;
    int credit_pulses;
    int swap_count;
    int writes_issued;
    int errors;
    int checks;
    int cycle_count;
    logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] last_address;
    bit have_last;

    tb_clock_gen u_clock (
        .clock_in  (clock_in),
        .reset_n_in(reset_n_in)
    );

    display_buffers u_dut (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .pixel_write_valid  (pixel_write_valid),
        .pixel_write_address(pixel_write_address),
        .pixel_write_data   (pixel_write_data),
        .switch_write_buffer(switch_write_buffer),
        .pixel_read_address (pixel_read_address),
        .pixel_write_credit (pixel_write_credit),
        .pixel_read_data    (pixel_read_data),
        .buffer_swapped     (buffer_swapped)
    );

    // Displayed pixel or blank past the frame
    function automatic logic [display_pkg::PIXEL_WIDTH-1:0] ref_pixel(
        input logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] address
    );
        if (address >= display_pkg::FRAME_PIXELS) begin
            return '0;
        end
        return frame_model[front_sel][address];
    endfunction

    task automatic check_pixel(
        input logic [display_pkg::PIXEL_WIDTH-1:0] got,
        input logic [display_pkg::PIXEL_WIDTH-1:0] expected,
        input logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] address
    );
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at %0t: pixel %0d read %h, expected %h",
                     $time, address, got, expected);
        end
    endtask

    // A credit pulse must match a spent credit
    task automatic check_credit(input logic credit);
        if (credit === 1'b1) begin
            checks++;
            if (credits_held >= display_pkg::WRITE_CREDITS) begin
                errors++;
                $display("credit returned at %0t while the host already holds all %0d",
                         $time, display_pkg::WRITE_CREDITS);
            end else begin
                credits_held++;
                credit_pulses++;
            end
        end
    endtask

    task automatic check_count(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // Read data belongs to the address of the previous cycle
    always @(posedge clock_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAIL");
            $finish;
        end else if (reset_n_in) begin
            if (have_last) begin
                check_pixel(pixel_read_data, ref_pixel(last_address), last_address);
            end
            check_credit(pixel_write_credit);
            // Reads from the next cycle on see the other frame
            if (buffer_swapped === 1'b1) begin
                front_sel = !front_sel;
                swap_count++;
            end
            last_address = pixel_read_address;
            have_last = 1'b1;
        end
    end

    // One frame scan with host writes from the queue and an optional switch edge
    task automatic run_scan(input int switch_at, input bit late_write);
        int index;
        logic [display_pkg::PIXEL_ADDRESS_WIDTH+display_pkg::PIXEL_WIDTH-1:0] entry;
        logic [display_pkg::PIXEL_ADDRESS_WIDTH-1:0] address;
        for (index = 0; index < SCAN_CYCLES; index++) begin
            @(posedge clock_in);
            #1;
            if (index < 4) begin
                pixel_read_address = '0;
            end else begin
                pixel_read_address = display_pkg::PIXEL_ADDRESS_WIDTH'(index - 4);
            end
            pixel_write_valid = 1'b0;
            // A last write keeps the write path busy into the address zero period
            if (late_write && index == SCAN_CYCLES - 1) begin
                queue_write($urandom % display_pkg::FRAME_PIXELS, $urandom % 16);
            end
            if (((index >= WRITE_START && index < WRITE_STOP) || index == SCAN_CYCLES - 1) &&
                write_queue.size() > 0 && credits_held > 0) begin
                entry = write_queue.pop_front();
                address = entry[display_pkg::PIXEL_ADDRESS_WIDTH+display_pkg::PIXEL_WIDTH-1:
                                display_pkg::PIXEL_WIDTH];
                pixel_write_valid = 1'b1;
                pixel_write_address = address;
                pixel_write_data = entry[display_pkg::PIXEL_WIDTH-1:0];
                credits_held--;
                writes_issued++;
                // Back frame only and only inside the frame
                if (address < display_pkg::FRAME_PIXELS) begin
                    frame_model[!front_sel][address] = pixel_write_data;
                end
            end
            if (index == switch_at) begin
                switch_write_buffer = 1'b1;
            end
            if (index == switch_at + 20) begin
                switch_write_buffer = 1'b0;
            end
        end
    endtask

    task automatic queue_write(input int address, input int data);
        write_queue.push_back({display_pkg::PIXEL_ADDRESS_WIDTH'(address),
                               display_pkg::PIXEL_WIDTH'(data)});
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        int index;
        void'($urandom(32'h322b));
        pixel_write_valid = 1'b0;
        pixel_write_address = '0;
        pixel_write_data = '0;
        switch_write_buffer = 1'b0;
        pixel_read_address = '0;
        credits_held = display_pkg::WRITE_CREDITS;
        for (index = 0; index < display_pkg::FRAME_PIXELS; index++) begin
            frame_model[0][index] = '0;
            frame_model[1][index] = '0;
        end
        wait (reset_n_in === 1'b1);

        // Quiet scan with all pixels blank and no pulses
        mark = errors;
        run_scan(-1, 1'b0);
        check_count("credit pulses", credit_pulses, 0);
        check_count("swaps", swap_count, 0);
        report_test("test 1 reset state", mark);

        // Random writes with the switch raised mid-scan
        mark = errors;
        for (index = 0; index < 300; index++) begin
            queue_write($urandom % display_pkg::FRAME_PIXELS, $urandom % 16);
        end
        run_scan(200000, 1'b1);
        check_count("swaps in scan 2", swap_count, 0);

        // All lanes of a few words back to back
        for (index = 0; index < 24; index++) begin
            queue_write(800 + index, (index * 5 + 3) % 16);
        end
        run_scan(200000, 1'b1);
        check_count("swaps after scan 3", swap_count, 1);
        report_test("test 2 random writes and swap", mark);

        // Full rate writes with a few past the frame
        mark = errors;
        for (index = 0; index < 40; index++) begin
            if (index % 5 == 4) begin
                queue_write(display_pkg::FRAME_PIXELS + ($urandom % 6000), $urandom % 16);
            end else begin
                queue_write($urandom % display_pkg::FRAME_PIXELS, $urandom % 16);
            end
        end
        run_scan(200000, 1'b1);
        check_count("swaps after scan 4", swap_count, 2);
        report_test("test 3 word neighbours", mark);

        mark = errors;
        run_scan(200000, 1'b0);
        check_count("credits held", credits_held, display_pkg::WRITE_CREDITS);
        check_count("credit pulses", credit_pulses, writes_issued);
        check_count("swaps after scan 5", swap_count, 3);
        report_test("test 4 credits", mark);

        // Scan 6 shows the frame of scan 4 again
        mark = errors;
        run_scan(-1, 1'b0);
        check_count("swaps after scan 6", swap_count, 4);
        report_test("test 5 one swap per edge", mark);
        report_test("test 6 second swap restores frame", mark);

        @(posedge clock_in);
        #1;
        pixel_read_address = '0;
        repeat (3) @(posedge clock_in);
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/display_pkg.sv
logic/pixel_command_decode.sv
logic/pixel_word_update.sv
logic/frame_buffer_pair.sv
logic/buffer_swap_control.sv
logic/display_readout.sv
logic/display_buffers.sv
bench/tb_clock_gen.sv
bench/display_buffers_assertions.sv
bench/display_buffers_tb.sv

// ==== Makefile ====
# Verilator build and run of the display frame store testbench

VERILATOR ?= verilator
TOP ?= display_buffers_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
